/* common/spi_bus_pkg.sv */
package spi_bus_pkg;

	// Field widths of one single-lane frame
	localparam int CMD_W     = 8;
	localparam int ADDR_W    = 24;
	localparam int DATA_W    = 32;
	localparam int FRAME_W   = CMD_W + ADDR_W + DATA_W; // Longest shifted frame
	localparam int BIT_CNT_W = 7;  // Counts up to FRAME_W and beyond
	localparam int DUMMY_W   = 4;

	typedef logic [CMD_W-1:0]     cmd_t;
	typedef logic [ADDR_W-1:0]    addr_t;
	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [FRAME_W-1:0]   frame_t;
	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
	typedef logic [DUMMY_W-1:0]   dummy_t;

	// One-cycle strobes tied to SCLK edges
	typedef struct packed {
		logic launch; // Present next mosi bit
		logic sample; // Capture miso
	} sclk_strobe_t;

endpackage

/* common/spi_frame_pkg.sv */
package spi_frame_pkg;

	// Command types, unknown codes fall back to cmd_only
	typedef enum logic [2:0] {
		cmd_only       = 3'd0,
		cmd_read       = 3'd1,
		cmd_addr_read  = 3'd2, // Only type with dummy cycles
		cmd_write      = 3'd3,
		cmd_addr_write = 3'd4,
		cmd_addr       = 3'd5
	} cmd_type_e;

	// Request as presented by the CPU
	typedef struct packed {
		cmd_type_e             cmd_type;
		spi_bus_pkg::cmd_t     command;
		spi_bus_pkg::addr_t    address;
		spi_bus_pkg::data_t    data;
		spi_bus_pkg::bit_cnt_t bit_count;    // Write or read length
		spi_bus_pkg::dummy_t   dummy_cycles;
	} xfer_req_t;

	// Per-frame bit budget
	typedef struct packed {
		spi_bus_pkg::bit_cnt_t tx_bits;
		spi_bus_pkg::dummy_t   dummy_cycles;
		spi_bus_pkg::bit_cnt_t rx_bits;
		spi_bus_pkg::bit_cnt_t sclk_cycles; // tx + dummy + rx
	} xfer_plan_t;

	// Master FSM
	typedef enum logic [1:0] {
		idle     = 2'd0,
		setup    = 2'd1,
		transfer = 2'd2
	} ctrl_state_e;

endpackage

/* logic/spi_flash_master.sv */
`timescale 1ns/1ns

module spi_flash_master #(
	parameter int CLKS_PER_HALF_SCLK = 2,
	parameter int CPOL               = 1,
	parameter int CPHA               = 1
) (
	input  logic                     rst,       // System clock
	input  logic                     clk,       // Async reset, active high
	input  spi_frame_pkg::xfer_req_t req,
	input  logic                     valid,
	output logic                     ready,
	output spi_bus_pkg::data_t       data_out,
	output logic                     valid_out,
	output logic                     sclk,
	output logic                     ss_n,
	output logic                     mosi,
	input  logic                     miso
);

	logic                         load;
	logic                         start;
	logic                         done;
	spi_bus_pkg::frame_t          frame;
	spi_frame_pkg::xfer_plan_t    plan;
	spi_bus_pkg::sclk_strobe_t    strobe;
	spi_bus_pkg::data_t           rx_data;

	spi_master_ctrl u_ctrl (
		.rst       (rst),
		.clk       (clk),
		.valid     (valid),
		.done      (done),
		.rx_data   (rx_data),
		.load      (load),
		.start     (start),
		.ss_n      (ss_n),
		.ready     (ready),
		.valid_out (valid_out),
		.data_out  (data_out)
	);

	spi_frame_setup u_setup (
		.rst   (rst),
		.clk   (clk),
		.load  (load),
		.req   (req),
		.frame (frame),
		.plan  (plan)
	);

	spi_sclk_gen #(
		.CLKS_PER_HALF_SCLK (CLKS_PER_HALF_SCLK),
		.CPOL               (CPOL),
		.CPHA               (CPHA)
	) u_sclk_gen (
		.rst         (rst),
		.clk         (clk),
		.start       (start),
		.sclk_cycles (plan.sclk_cycles),
		.sclk        (sclk),
		.strobe      (strobe),
		.done        (done)
	);

	// Transmit side follows launch strobes
	spi_tx_shifter u_tx (
		.rst     (rst),
		.clk     (clk),
		.start   (start),
		.launch  (strobe.launch),
		.frame   (frame),
		.tx_bits (plan.tx_bits),
		.mosi    (mosi)
	);

	spi_rx_shifter u_rx (
		.rst     (rst),
		.clk     (clk),
		.start   (start),
		.sample  (strobe.sample),
		.miso    (miso),
		.plan    (plan),
		.rx_data (rx_data)
	);

endmodule

/* logic/spi_frame_setup.sv */
`timescale 1ns/1ns

module spi_frame_setup (
	input  logic                       rst,
	input  logic                       clk,
	input  logic                       load,
	input  spi_frame_pkg::xfer_req_t   req,
	output spi_bus_pkg::frame_t        frame,
	output spi_frame_pkg::xfer_plan_t  plan
);

	logic                      has_addr;
	logic                      is_read;
	logic                      is_write;
	logic                      use_dummy;
	spi_bus_pkg::bit_cnt_t     data_bits;
	spi_bus_pkg::data_t        data_just;
	spi_bus_pkg::frame_t       next_frame;
	spi_frame_pkg::xfer_plan_t next_plan;

	// Phases present per command type
	always_comb begin
		has_addr  = 1'b0;
		is_read   = 1'b0;
		is_write  = 1'b0;
		use_dummy = 1'b0;
		case (req.cmd_type)
			spi_frame_pkg::cmd_read: is_read = 1'b1;
			spi_frame_pkg::cmd_addr_read: begin
				has_addr  = 1'b1;
				is_read   = 1'b1;
				use_dummy = 1'b1;
			end
			spi_frame_pkg::cmd_write: is_write = 1'b1;
			spi_frame_pkg::cmd_addr_write: begin
				has_addr = 1'b1;
				is_write = 1'b1;
			end
			spi_frame_pkg::cmd_addr: has_addr = 1'b1;
			default: ; // Command byte only
		endcase
	end

	// Data phase never longer than one data word
	assign data_bits = (req.bit_count > spi_bus_pkg::bit_cnt_t'(spi_bus_pkg::DATA_W)) ?
		spi_bus_pkg::bit_cnt_t'(spi_bus_pkg::DATA_W) : req.bit_count;

	// Low data bits moved up to the MSB end
	assign data_just = is_write ?
		spi_bus_pkg::data_t'(req.data << (spi_bus_pkg::DATA_W - int'(data_bits))) : '0;

	always_comb begin
		if (has_addr) begin
			next_frame = {req.command, req.address, data_just};
		end else begin
			next_frame = {req.command, data_just, {spi_bus_pkg::ADDR_W{1'b0}}};
		end
	end

	always_comb begin
		next_plan.tx_bits = spi_bus_pkg::bit_cnt_t'(spi_bus_pkg::CMD_W);
		if (has_addr)
			next_plan.tx_bits += spi_bus_pkg::bit_cnt_t'(spi_bus_pkg::ADDR_W);
		if (is_write)
			next_plan.tx_bits += data_bits;
		next_plan.dummy_cycles = use_dummy ? req.dummy_cycles : '0;
		next_plan.rx_bits      = is_read ? data_bits : '0;
		next_plan.sclk_cycles  = next_plan.tx_bits + next_plan.rx_bits
			+ spi_bus_pkg::bit_cnt_t'(next_plan.dummy_cycles);
	end

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			plan <= '0;
		end else if (load) begin
			plan <= next_plan;
		end
	end

	always_ff @(posedge rst) begin
		if (load)
			frame <= next_frame; // Held until the next request
	end

endmodule

/* logic/spi_master_ctrl.sv */
`timescale 1ns/1ns

module spi_master_ctrl (
	input  logic               rst,
	input  logic               clk,
	input  logic               valid,
	input  logic               done,
	input  spi_bus_pkg::data_t rx_data,
	output logic               load,
	output logic               start,
	output logic               ss_n,
	output logic               ready,
	output logic               valid_out,
	output spi_bus_pkg::data_t data_out
);

	spi_frame_pkg::ctrl_state_e state;
	logic                       armed; // valid seen low since last acceptance

	// Acceptance, ready is only high in idle
	assign load  = valid && ready && armed;
	assign start = (state == spi_frame_pkg::setup);

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			armed <= 1'b1;
		end else if (load) begin
			armed <= 1'b0;
		end else if (!valid) begin
			armed <= 1'b1;
		end
	end

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			state     <= spi_frame_pkg::idle;
			ss_n      <= 1'b1;
			ready     <= 1'b1;
			valid_out <= 1'b0;
			data_out  <= '0;
		end else begin
			valid_out <= 1'b0; // Single cycle pulse
			case (state)
				spi_frame_pkg::idle: begin
					if (load) begin
						ready <= 1'b0;
						state <= spi_frame_pkg::setup;
					end
				end
				spi_frame_pkg::setup: begin
					// Plan is registered by now
					ss_n  <= 1'b0;
					state <= spi_frame_pkg::transfer;
				end
				spi_frame_pkg::transfer: begin
					if (done) begin
						ss_n      <= 1'b1;
						ready     <= 1'b1;
						valid_out <= 1'b1;
						data_out  <= rx_data;
						state     <= spi_frame_pkg::idle;
					end
				end
				default: begin
					ss_n  <= 1'b1;
					ready <= 1'b1;
					state <= spi_frame_pkg::idle;
				end
			endcase
		end
	end

	// No new request while the slave is selected
	a_sel_not_ready : assert property (@(posedge rst) disable iff (clk)
		!ss_n |-> !ready);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ns \
	--top-module spi_flash_master_tb -f spi_flash_master.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q 'All tests passed!' sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

/* serial/spi_rx_shifter.sv */
`timescale 1ns/1ns

module spi_rx_shifter (
	input  logic                      rst,
	input  logic                      clk,
	input  logic                      start,
	input  logic                      sample,
	input  logic                      miso,
	input  spi_frame_pkg::xfer_plan_t plan,
	output spi_bus_pkg::data_t        rx_data
);

	spi_bus_pkg::bit_cnt_t sample_cnt;
	spi_bus_pkg::bit_cnt_t skip_bits;
	spi_bus_pkg::bit_cnt_t end_bits;
	logic                  in_window;

	// Transmit and dummy samples carry no read data
	assign skip_bits = plan.tx_bits + spi_bus_pkg::bit_cnt_t'(plan.dummy_cycles);
	assign end_bits  = skip_bits + plan.rx_bits;
	assign in_window = (sample_cnt >= skip_bits) && (sample_cnt < end_bits);

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			sample_cnt <= '0;
		end else if (start) begin
			sample_cnt <= '0;
		end else if (sample) begin
			sample_cnt <= sample_cnt + 1'b1;
		end
	end

	// Shift in at the bottom so short reads end up right-aligned
	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			rx_data <= '0;
		end else if (start) begin
			rx_data <= '0;
		end else if (sample && in_window) begin
			rx_data <= {rx_data[spi_bus_pkg::DATA_W-2:0], miso};
		end
	end

endmodule

/* serial/spi_sclk_gen.sv */
`timescale 1ns/1ns

module spi_sclk_gen #(
	parameter int CLKS_PER_HALF_SCLK = 2,
	parameter int CPOL               = 1,
	parameter int CPHA               = 1
) (
	input  logic                      rst,
	input  logic                      clk,
	input  logic                      start,
	input  spi_bus_pkg::bit_cnt_t     sclk_cycles,
	output logic                      sclk,
	output spi_bus_pkg::sclk_strobe_t strobe,
	output logic                      done
);

	localparam int   CNT_W    = (CLKS_PER_HALF_SCLK > 1) ? $clog2(CLKS_PER_HALF_SCLK) : 1;
	localparam logic IDLE_LVL = (CPOL != 0);
	localparam logic PHASE1   = (CPHA != 0);

	logic [CNT_W-1:0]                div_cnt;
	logic [spi_bus_pkg::BIT_CNT_W:0] edges_left; // Two per SCLK period
	logic                            active;
	logic                            edge_now;
	logic                            leading;
	logic                            trailing;

	assign edge_now = active && (div_cnt == CNT_W'(CLKS_PER_HALF_SCLK - 1));
	assign leading  = edge_now && (sclk == IDLE_LVL);
	assign trailing = edge_now && (sclk != IDLE_LVL);

	// Mode 0 and 2 need the first bit before the first edge
	assign strobe.launch = PHASE1 ? leading : (trailing || start);
	assign strobe.sample = PHASE1 ? trailing : leading;

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			sclk       <= IDLE_LVL;
			div_cnt    <= '0;
			edges_left <= '0;
			active     <= 1'b0;
			done       <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				sclk       <= IDLE_LVL;
				div_cnt    <= '0;
				edges_left <= {sclk_cycles, 1'b0};
				active     <= 1'b1;
			end else if (edge_now) begin
				sclk       <= ~sclk;
				div_cnt    <= '0;
				edges_left <= edges_left - 1'b1;
				if (edges_left == 1) begin // Last edge of the frame
					active <= 1'b0;
					done   <= 1'b1;
				end
			end else if (active) begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// start only arrives while no frame runs
	a_strobe_excl : assert property (@(posedge rst) disable iff (clk)
		!(strobe.launch && strobe.sample));

endmodule

/* serial/spi_tx_shifter.sv */
`timescale 1ns/1ns

module spi_tx_shifter (
	input  logic                  rst,
	input  logic                  clk,
	input  logic                  start,
	input  logic                  launch,
	input  spi_bus_pkg::frame_t   frame,
	input  spi_bus_pkg::bit_cnt_t tx_bits,
	output logic                  mosi
);

	spi_bus_pkg::frame_t   shift_q;
	spi_bus_pkg::frame_t   src;
	spi_bus_pkg::bit_cnt_t remaining;
	spi_bus_pkg::bit_cnt_t left;

	// start may come with the first launch
	assign src  = start ? frame : shift_q;
	assign left = start ? tx_bits : remaining;

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			remaining <= '0;
			mosi      <= 1'b0;
		end else if (launch && (left != '0)) begin
			mosi      <= src[spi_bus_pkg::FRAME_W-1]; // MSB first
			remaining <= left - 1'b1;
		end else if (start || launch) begin
			mosi      <= 1'b0; // Idle low once the frame is out
			remaining <= left;
		end
	end

	always_ff @(posedge rst) begin
		if (start || launch)
			shift_q <= (launch && (left != '0)) ? (src << 1) : src;
	end

	// Every launched bit must come from the loaded frame
	a_tx_fits_frame : assert property (@(posedge rst) disable iff (clk)
		start |-> (tx_bits != '0)
			&& (tx_bits <= spi_bus_pkg::bit_cnt_t'(spi_bus_pkg::FRAME_W)));

endmodule

/* spi_flash_master.f */
common/spi_bus_pkg.sv
common/spi_frame_pkg.sv
serial/spi_sclk_gen.sv
serial/spi_tx_shifter.sv
serial/spi_rx_shifter.sv
logic/spi_frame_setup.sv
logic/spi_master_ctrl.sv
logic/spi_flash_master.sv
verification/spi_flash_model.sv
verification/spi_flash_master_tb.sv

/* verification/spi_flash_master_tb.sv */
`timescale 1ns/1ns

module spi_flash_master_tb;

	localparam int          NUM_ROWS       = 12;
	localparam int          TIMEOUT_CYCLES = 2000;
	localparam int          HOLD_CYCLES    = 8;
	localparam logic [31:0] SEED           = 32'h9309d5fd;

	typedef struct packed {
		spi_frame_pkg::cmd_type_e ctype;
		spi_bus_pkg::cmd_t        cmd;
		spi_bus_pkg::addr_t       addr;
		spi_bus_pkg::data_t       data;
		spi_bus_pkg::bit_cnt_t    bc;
		spi_bus_pkg::dummy_t      dc;
		spi_bus_pkg::data_t       resp;     // Word the flash answers with
		spi_bus_pkg::bit_cnt_t    exp_tx;   // mosi bits of the frame
		spi_bus_pkg::data_t       exp_read;
	} row_t;

	logic                     rst = 1'b0; // System clock
	logic                     clk;        // Reset
	spi_frame_pkg::xfer_req_t req;
	logic                     valid;
	logic                     ready;
	spi_bus_pkg::data_t       data_out;
	logic                     valid_out;
	logic                     sclk;
	logic                     ss_n;
	logic                     mosi;
	logic                     miso;
	spi_bus_pkg::bit_cnt_t    model_skip;
	spi_bus_pkg::bit_cnt_t    model_rx;
	spi_bus_pkg::data_t       model_resp;
	logic [127:0]             mosi_stream;
	int                       periods;
	row_t                     rows [NUM_ROWS];
	int                       checks   = 0;
	int                       errors   = 0;
	int                       timeouts = 0;

	always #10 rst = ~rst;

	spi_flash_master #(
		.CLKS_PER_HALF_SCLK (2),
		.CPOL               (1),
		.CPHA               (1)
	) uut (
		.rst       (rst),
		.clk       (clk),
		.req       (req),
		.valid     (valid),
		.ready     (ready),
		.data_out  (data_out),
		.valid_out (valid_out),
		.sclk      (sclk),
		.ss_n      (ss_n),
		.mosi      (mosi),
		.miso      (miso)
	);

	spi_flash_model u_flash (
		.sclk        (sclk),
		.ss_n        (ss_n),
		.mosi        (mosi),
		.skip        (model_skip),
		.rx_bits     (model_rx),
		.response    (model_resp),
		.miso        (miso),
		.mosi_stream (mosi_stream),
		.periods     (periods)
	);

	function automatic logic type_reads(spi_frame_pkg::cmd_type_e t);
		return t == spi_frame_pkg::cmd_read || t == spi_frame_pkg::cmd_addr_read;
	endfunction

	function automatic logic type_writes(spi_frame_pkg::cmd_type_e t);
		return t == spi_frame_pkg::cmd_write || t == spi_frame_pkg::cmd_addr_write;
	endfunction

	function automatic logic type_has_addr(spi_frame_pkg::cmd_type_e t);
		return t == spi_frame_pkg::cmd_addr_read || t == spi_frame_pkg::cmd_addr_write
			|| t == spi_frame_pkg::cmd_addr;
	endfunction

	function automatic spi_bus_pkg::data_t low_bits(spi_bus_pkg::data_t v,
		spi_bus_pkg::bit_cnt_t n);
		spi_bus_pkg::data_t mask;
		if (n >= 7'd32)
			mask = '1;
		else
			mask = (32'd1 << n) - 32'd1;
		return v & mask;
	endfunction

	// Transmit bits right-aligned, command byte oldest
	function automatic logic [127:0] tx_stream(row_t r);
		logic [127:0] s;
		s = 128'(r.cmd);
		if (type_has_addr(r.ctype))
			s = (s << 24) | 128'(r.addr);
		if (type_writes(r.ctype))
			s = (s << r.bc) | 128'(low_bits(r.data, r.bc));
		return s;
	endfunction

	function automatic row_t make_row(spi_frame_pkg::cmd_type_e t, spi_bus_pkg::cmd_t c,
		spi_bus_pkg::addr_t a, spi_bus_pkg::data_t d, spi_bus_pkg::bit_cnt_t bc,
		spi_bus_pkg::dummy_t dc, spi_bus_pkg::data_t resp, spi_bus_pkg::bit_cnt_t exp_tx,
		spi_bus_pkg::data_t exp_read);
		row_t r;
		r.ctype    = t;
		r.cmd      = c;
		r.addr     = a;
		r.data     = d;
		r.bc       = bc;
		r.dc       = dc;
		r.resp     = resp;
		r.exp_tx   = exp_tx;
		r.exp_read = exp_read;
		return r;
	endfunction

	task automatic fill_table();
		spi_bus_pkg::data_t r0;
		spi_bus_pkg::data_t r1;
		r0 = $urandom();
		r1 = $urandom();
		rows[0]  = make_row(spi_frame_pkg::cmd_only, 8'h06, '0, '0, 7'd0, 4'd0, '0, 7'd8, '0);
		rows[1]  = make_row(spi_frame_pkg::cmd_read, 8'h9f, '0, '0, 7'd24, 4'd0,
			32'h12ef4018, 7'd8, 32'h00ef4018);
		rows[2]  = make_row(spi_frame_pkg::cmd_addr_read, 8'h0b, 24'($urandom()), '0,
			7'd32, 4'd8, r0, 7'd32, r0);
		rows[3]  = make_row(spi_frame_pkg::cmd_addr_read, 8'h03, 24'h123456, '0, 7'd8, 4'd0,
			32'hffffffa5, 7'd32, 32'h000000a5);
		rows[4]  = make_row(spi_frame_pkg::cmd_write, 8'h01, '0, 32'h00000302, 7'd8, 4'd0,
			'0, 7'd16, '0);
		rows[5]  = make_row(spi_frame_pkg::cmd_addr_write, 8'h02, 24'($urandom()), $urandom(),
			7'd32, 4'd0, '0, 7'd64, '0);
		rows[6]  = make_row(spi_frame_pkg::cmd_addr, 8'h20, 24'h001000, '0, 7'd0, 4'd0,
			'0, 7'd32, '0);
		rows[7]  = make_row(spi_frame_pkg::cmd_write, 8'h31, '0, 32'h3, 7'd1, 4'd0, '0, 7'd9, '0);
		rows[8]  = make_row(spi_frame_pkg::cmd_read, 8'h05, '0, '0, 7'd1, 4'd0, 32'h3, 7'd8, 32'h1);
		rows[9]  = make_row(spi_frame_pkg::cmd_addr_read, 8'h6b, 24'($urandom()), '0, 7'd1,
			4'd3, r1, 7'd32, low_bits(r1, 7'd1));
		rows[10] = make_row(spi_frame_pkg::cmd_addr_write, 8'h32, 24'($urandom()), $urandom(),
			7'd8, 4'd5, '0, 7'd40, '0); // Dummy count ignored for writes
		rows[11] = make_row(spi_frame_pkg::cmd_type_e'(3'd7), 8'hab, 24'hffffff, 32'hffffffff,
			7'd16, 4'd2, 32'hffff, 7'd8, '0);
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] exp,
		input logic [127:0] got);
		$display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, got);
		errors++;
	endtask

	// Idle SCLK level outside a frame
	always @(negedge rst) begin
		if (clk === 1'b0 && ss_n === 1'b1 && sclk !== 1'b1)
			report_mismatch("sclk", 128'd1, 128'(sclk));
	end

	task automatic apply_row(input int idx, input row_t r);
		spi_bus_pkg::bit_cnt_t rx;
		spi_bus_pkg::dummy_t   dum;
		logic [127:0]          exp_stream;
		int                    cycles;
		logic                  seen;
		rx         = type_reads(r.ctype) ? r.bc : '0;
		dum        = (r.ctype == spi_frame_pkg::cmd_addr_read) ? r.dc : '0;
		exp_stream = tx_stream(r) << (int'(dum) + int'(rx)); // mosi idles low after tx
		@(negedge rst);
		model_skip       = r.exp_tx + spi_bus_pkg::bit_cnt_t'(dum);
		model_rx         = rx;
		model_resp       = r.resp;
		req.cmd_type     = r.ctype;
		req.command      = r.cmd;
		req.address      = r.addr;
		req.data         = r.data;
		req.bit_count    = r.bc;
		req.dummy_cycles = r.dc;
		valid            = 1'b1;
		@(negedge rst);
		checks++;
		if (ready !== 1'b0)
			report_mismatch("ready", '0, 128'(ready));
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < TIMEOUT_CYCLES) begin
			@(negedge rst);
			cycles++;
			if (valid_out === 1'b1)
				seen = 1'b1;
			else if (ready !== 1'b0)
				report_mismatch("ready", '0, 128'(ready));
		end
		if (!seen) begin
			$display("Row %0d got no valid_out within %0d cycles", idx, TIMEOUT_CYCLES);
			timeouts++;
		end else begin
			checks += 5;
			if (ss_n !== 1'b1)
				report_mismatch("ss_n", 128'd1, 128'(ss_n));
			if (ready !== 1'b1)
				report_mismatch("ready", 128'd1, 128'(ready));
			if (data_out !== r.exp_read)
				report_mismatch("data_out", 128'(r.exp_read), 128'(data_out));
			if (periods != int'(r.exp_tx) + int'(dum) + int'(rx))
				report_mismatch("sclk periods", 128'(int'(r.exp_tx) + int'(dum) + int'(rx)),
					128'(periods));
			if (mosi_stream !== exp_stream)
				report_mismatch("mosi", exp_stream, mosi_stream);
			// valid stays high, no second frame may start
			for (int k = 0; k < HOLD_CYCLES; k++) begin
				@(negedge rst);
				checks += 2;
				if (valid_out !== 1'b0)
					report_mismatch("valid_out", '0, 128'(valid_out));
				if (ss_n !== 1'b1)
					report_mismatch("ss_n", 128'd1, 128'(ss_n));
			end
		end
		valid = 1'b0;
	endtask

	initial begin
		void'($urandom(SEED));
		clk        = 1'b1;
		valid      = 1'b0;
		req        = '0;
		model_skip = '0;
		model_rx   = '0;
		model_resp = '0;
		fill_table();
		repeat (4) @(negedge rst);
		clk = 1'b0;
		for (int i = 0; i < NUM_ROWS && timeouts == 0; i++)
			apply_row(i, rows[i]);
		$display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* verification/spi_flash_model.sv */
`timescale 1ns/1ns

module spi_flash_model (
	input  logic                  sclk,
	input  logic                  ss_n,
	input  logic                  mosi,
	input  spi_bus_pkg::bit_cnt_t skip,     // Periods before read data starts
	input  spi_bus_pkg::bit_cnt_t rx_bits,
	input  spi_bus_pkg::data_t    response,
	output logic                  miso,
	output logic [127:0]          mosi_stream,
	output int                    periods
);

	logic sclk_q = 1'b1;
	int   falls  = 0;

	initial begin
		miso        = 1'b0;
		mosi_stream = '0;
		periods     = 0;
	end

	// Mode 3 flash, samples on rising sclk and drives on falling sclk
	always @(negedge ss_n or posedge sclk or negedge sclk) begin
		int idx;
		if (ss_n === 1'b0) begin
			if (sclk === sclk_q) begin
				// Select just went low
				mosi_stream = '0;
				periods     = 0;
				falls       = 0;
				miso        = 1'b0;
			end else if (sclk === 1'b1) begin
				mosi_stream = {mosi_stream[126:0], mosi};
				periods++;
			end else begin
				idx = falls - int'(skip);
				if (idx >= 0 && idx < int'(rx_bits))
					miso = response[int'(rx_bits) - 1 - idx]; // MSB of the read first
				else
					miso = 1'b0;
				falls++;
			end
		end
		sclk_q = sclk;
	end

endmodule
